//--- build.f
+incdir+design
+incdir+test
design/serv_pkg.sv
design/serv_counter.sv
design/serv_decode.sv
design/serv_regfile.sv
design/serv_alu.sv
design/serv_ctrl.sv
design/serv_mem_if.sv
design/serv_top.sv
test/tb_serv.sv

//--- design/serv_alu.sv
`timescale 1ns/100ps

module serv_alu (
   input  logic                clk,
   input  serv_pkg::alu_ctrl_t i_alu,
   input  logic                i_rs1,
   input  logic                i_rs2,
   input  logic                i_imm,
   output logic                o_rd,
   output logic                o_cmp
);

   logic op_b;
   logic b_add;
   logic sum;
   logic carry;
   logic carry_next;
   logic init_q;
   logic eq;
   logic lt;
   logic cmp;

   assign op_b       = i_alu.op_b_imm ? i_imm : i_rs2;
   assign b_add      = op_b ^ i_alu.sub;  // Inverted operand for subtract.
   assign sum        = i_rs1 ^ b_add ^ carry;
   assign carry_next = (i_rs1 & b_add) | (carry & (i_rs1 ^ b_add));

   // Carry starts at sub, so a - b is a + ~b + 1.
   always_ff @(posedge clk) begin
      carry  <= i_alu.en ? carry_next : i_alu.sub;
      init_q <= i_alu.init;
   end

   // The last compare cycle sees bit 31, so its lt value is final.
   always_ff @(posedge clk) begin
      if (i_alu.init) begin
         eq <= (init_q ? eq : 1'b1) & ~(i_rs1 ^ op_b);
         if (i_rs1 ^ op_b)
            lt <= i_alu.cmp_uns ? op_b : i_rs1;
         else
            lt <= ~carry_next;
      end
   end

   assign cmp   = i_alu.cmp_sel ? lt : eq;
   assign o_cmp = cmp ^ i_alu.cmp_neg;

   always_comb begin
      case (i_alu.rd_sel)
         serv_pkg::ADD: o_rd = sum;
         serv_pkg::LT:  o_rd = init_q & cmp;  // Flag in bit 0 only.
         serv_pkg::XOR: o_rd = i_rs1 ^ op_b;
         serv_pkg::OR:  o_rd = i_rs1 | op_b;
         serv_pkg::AND: o_rd = i_rs1 & op_b;
         default:       o_rd = sum;
      endcase
   end

endmodule

//--- design/serv_counter.sv
`timescale 1ns/100ps
`include "serv_defines.svh"

module serv_counter (
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic                   i_en,
   output logic [`SERV_CNT_W-1:0] o_cnt,
   output logic                   o_done
);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_cnt <= '0;
      end else if (i_en) begin
         o_cnt <= o_cnt + 1'b1;  // Wraps to 0 after bit 31.
      end
   end

   // Last bit of the phase.
   assign o_done = &o_cnt;

endmodule

//--- design/serv_ctrl.sv
`timescale 1ns/100ps
`include "serv_defines.svh"

module serv_ctrl (
   input  logic                  clk,
   input  logic                  i_rst,
   input  serv_pkg::ctrl_ctrl_t  i_ctrl,
   input  logic                  i_cnt_done,
   input  logic                  i_imm,
   input  logic                  i_rs1,
   output logic [`SERV_XLEN-1:0] o_pc,
   output logic                  o_rd
);

   logic [`SERV_XLEN-1:0] pc;
   logic [2:0]            pos;  // One-hot marker for bits 0 to 2.
   logic                  c_plus4;
   logic                  c_off;
   logic                  off_a;
   logic                  plus4;
   logic                  offset;
   logic                  target;
   logic                  pc_next;

   assign plus4   = pc[0] ^ pos[2] ^ c_plus4;
   assign off_a   = i_ctrl.jalr ? i_rs1 : pc[0];
   assign offset  = off_a ^ i_imm ^ c_off;
   assign target  = offset & ~(i_ctrl.jalr & pos[0]);  // JALR clears bit 0.
   assign pc_next = i_ctrl.jump ? target : plus4;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         pc      <= `SERV_RESET_PC;
         pos     <= 3'b001;
         c_plus4 <= 1'b0;
         c_off   <= 1'b0;
      end else if (i_ctrl.en) begin
         pc      <= {pc_next, pc[`SERV_XLEN-1:1]};
         pos     <= i_cnt_done ? 3'b001 : {pos[1:0], 1'b0};
         c_plus4 <= ~i_cnt_done & ((pc[0] & pos[2]) | (c_plus4 & (pc[0] ^ pos[2])));
         c_off   <= ~i_cnt_done & ((off_a & i_imm) | (c_off & (off_a ^ i_imm)));
      end
   end

   assign o_pc = pc;
   assign o_rd = i_ctrl.auipc ? offset : plus4;  // Link address otherwise.

endmodule

//--- design/serv_decode.sv
`timescale 1ns/100ps
`include "serv_defines.svh"

module serv_decode (
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic [`SERV_XLEN-1:0]  i_ibus_rdt,
   input  logic                   i_ibus_ack,
   input  logic [`SERV_CNT_W-1:0] i_cnt,
   input  logic                   i_cnt_done,
   input  logic                   i_alu_cmp,
   input  logic                   i_dbus_ack,
   output logic                   o_ibus_cyc,
   output logic                   o_cnt_en,
   output serv_pkg::alu_ctrl_t    o_alu,
   output serv_pkg::rf_ctrl_t     o_rf,
   output serv_pkg::ctrl_ctrl_t   o_ctrl,
   output serv_pkg::mem_ctrl_t    o_mem,
   output logic                   o_imm,
   output serv_pkg::rd_source_t   o_rd_source
);

   serv_pkg::instr_u      instr;
   serv_pkg::phase_t      state;
   serv_pkg::opcode_t     opcode;
   logic [2:0]            funct3;
   logic                  go;
   logic                  running;
   logic                  mem_op;
   logic                  cmp_op;
   logic                  alu_op;
   logic [`SERV_XLEN-1:0] imm_word;

   always_ff @(posedge clk) begin
      if (i_ibus_ack)
         instr <= i_ibus_rdt;
   end

   assign opcode  = serv_pkg::opcode_t'(instr.rtype.opcode[6:2]);
   assign funct3  = instr.rtype.funct3;
   assign alu_op  = (opcode == serv_pkg::OP) | (opcode == serv_pkg::OPIMM);
   assign mem_op  = (opcode == serv_pkg::LOAD) | (opcode == serv_pkg::STORE);
   assign cmp_op  = (opcode == serv_pkg::BRANCH) | (alu_op & (funct3[2:1] == 2'b01));
   assign running = (state == serv_pkg::RUN);

   // Go is high the cycle after the fetch ack.
   always_ff @(posedge clk) begin
      if (i_rst) begin
         go    <= 1'b0;
         state <= serv_pkg::IDLE;
      end else begin
         go <= i_ibus_ack;
         case (state)
            serv_pkg::IDLE: begin
               if (go) begin
                  if (cmp_op)
                     state <= serv_pkg::COMPARE;
                  else if (mem_op)
                     state <= serv_pkg::MEM_INIT;
                  else
                     state <= serv_pkg::RUN;
               end
            end
            serv_pkg::COMPARE:  if (i_cnt_done) state <= serv_pkg::RUN;
            serv_pkg::MEM_INIT: if (i_cnt_done) state <= serv_pkg::MEM_WAIT;
            serv_pkg::MEM_WAIT: if (i_dbus_ack) state <= serv_pkg::RUN;
            serv_pkg::RUN:      if (i_cnt_done) state <= serv_pkg::IDLE;
            default:            state <= serv_pkg::IDLE;
         endcase
      end
   end

   assign o_ibus_cyc = (state == serv_pkg::IDLE) & ~go;
   assign o_cnt_en   = (state == serv_pkg::COMPARE) | (state == serv_pkg::MEM_INIT) | running;

   always_comb begin
      o_alu.en       = o_cnt_en;
      o_alu.init     = (state == serv_pkg::COMPARE);
      o_alu.sub      = cmp_op |
                       ((opcode == serv_pkg::OP) & instr.rtype.funct7[5] & (funct3 == 3'b000));
      o_alu.cmp_sel  = |funct3[2:1];
      o_alu.cmp_neg  = (opcode == serv_pkg::BRANCH) & funct3[0];
      o_alu.cmp_uns  = (funct3 == 3'b011) | (funct3[2:1] == 2'b11);
      o_alu.op_b_imm = (opcode == serv_pkg::OPIMM) | mem_op;
      o_alu.rd_sel   = serv_pkg::ADD;
      if (alu_op) begin
         case (funct3)
            3'b010, 3'b011: o_alu.rd_sel = serv_pkg::LT;
            3'b100:         o_alu.rd_sel = serv_pkg::XOR;
            3'b110:         o_alu.rd_sel = serv_pkg::OR;
            3'b111:         o_alu.rd_sel = serv_pkg::AND;
            default:        o_alu.rd_sel = serv_pkg::ADD;
         endcase
      end
   end

   always_comb begin
      o_rf.rd_en    = running & (opcode != serv_pkg::STORE) & (opcode != serv_pkg::BRANCH);
      o_rf.rd_addr  = instr.rtype.rd;
      o_rf.rs1_addr = instr.rtype.rs1;
      o_rf.rs2_addr = instr.rtype.rs2;

      o_ctrl.en     = running;
      o_ctrl.jump   = (opcode == serv_pkg::JAL) | (opcode == serv_pkg::JALR) |
                      ((opcode == serv_pkg::BRANCH) & i_alu_cmp);
      o_ctrl.jalr   = (opcode == serv_pkg::JALR);
      o_ctrl.auipc  = (opcode == serv_pkg::AUIPC);

      o_mem.en      = (state == serv_pkg::MEM_INIT) & i_cnt_done;
      o_mem.init    = (state == serv_pkg::MEM_INIT);
      o_mem.we      = (opcode == serv_pkg::STORE);
   end

   always_comb begin
      case (opcode)
         serv_pkg::JAL, serv_pkg::JALR, serv_pkg::AUIPC: o_rd_source = serv_pkg::CTRL;
         serv_pkg::LUI:  o_rd_source = serv_pkg::IMM;
         serv_pkg::LOAD: o_rd_source = serv_pkg::MEM;
         default:        o_rd_source = serv_pkg::ALU;
      endcase
   end

   // Full immediate per format, picked out one bit per count.
   always_comb begin
      case (opcode)
         serv_pkg::STORE:
            imm_word = {{20{instr.stype.imm_hi[6]}}, instr.stype.imm_hi, instr.stype.imm_lo};
         serv_pkg::BRANCH:
            imm_word = {{20{instr.stype.imm_hi[6]}}, instr.stype.imm_lo[0],
                        instr.stype.imm_hi[5:0], instr.stype.imm_lo[4:1], 1'b0};
         serv_pkg::LUI, serv_pkg::AUIPC:
            imm_word = {instr.rtype.funct7, instr.rtype.rs2, instr.rtype.rs1,
                        instr.rtype.funct3, 12'd0};
         serv_pkg::JAL:
            imm_word = {{12{instr.rtype.funct7[6]}}, instr.rtype.rs1, instr.rtype.funct3,
                        instr.rtype.rs2[0], instr.rtype.funct7[5:0], instr.rtype.rs2[4:1], 1'b0};
         default:
            imm_word = {{20{instr.rtype.funct7[6]}}, instr.rtype.funct7, instr.rtype.rs2};
      endcase
   end

   assign o_imm = imm_word[i_cnt];

endmodule

//--- design/serv_defines.svh
`ifndef SERV_DEFINES_SVH
`define SERV_DEFINES_SVH

// Width of a data word and of the program counter.
`define SERV_XLEN 32

// Bit position counter, one step per serial cycle.
`define SERV_CNT_W 5

// Architectural registers, x0 included.
`define SERV_REGS 32

// Address of the first instruction fetch.
`define SERV_RESET_PC 32'h0000_0000

`endif

//--- design/serv_mem_if.sv
`timescale 1ns/100ps
`include "serv_defines.svh"

module serv_mem_if (
   input  logic                  clk,
   input  logic                  i_rst,
   input  serv_pkg::mem_ctrl_t   i_mem,
   input  logic                  i_addr_bit,
   input  logic                  i_rs2,
   input  logic [`SERV_XLEN-1:0] i_dbus_rdt,
   input  logic                  i_dbus_ack,
   output logic [`SERV_XLEN-1:0] o_dbus_adr,
   output logic [`SERV_XLEN-1:0] o_dbus_dat,
   output logic                  o_dbus_we,
   output logic                  o_dbus_cyc,
   output logic                  o_rd
);

   logic [`SERV_XLEN-1:0] adr;
   logic [`SERV_XLEN-1:0] dat;
   logic                  cyc;

   always_ff @(posedge clk) begin
      if (i_rst)
         cyc <= 1'b0;
      else if (i_mem.en)
         cyc <= 1'b1;
      else if (i_dbus_ack)
         cyc <= 1'b0;
   end

   // Store data and load data share one shift register.
   always_ff @(posedge clk) begin
      if (i_mem.init) begin
         adr <= {i_addr_bit, adr[`SERV_XLEN-1:1]};
         dat <= {i_rs2, dat[`SERV_XLEN-1:1]};
      end else if (i_dbus_ack && !i_mem.we) begin
         dat <= i_dbus_rdt;
      end else if (!cyc) begin
         dat <= {1'b0, dat[`SERV_XLEN-1:1]};  // Held while the bus is busy.
      end
   end

   assign o_dbus_adr = adr;
   assign o_dbus_dat = dat;
   assign o_dbus_we  = i_mem.we;
   assign o_dbus_cyc = cyc;
   assign o_rd       = dat[0];

endmodule

//--- design/serv_pkg.sv
package serv_pkg;

   // Instruction bits 6:2.
   typedef enum logic [4:0] {
      LOAD   = 5'b00000,
      STORE  = 5'b01000,
      OPIMM  = 5'b00100,
      AUIPC  = 5'b00101,
      OP     = 5'b01100,
      LUI    = 5'b01101,
      BRANCH = 5'b11000,
      JALR   = 5'b11001,
      JAL    = 5'b11011
   } opcode_t;

   typedef enum logic [2:0] {IDLE, COMPARE, MEM_INIT, MEM_WAIT, RUN} phase_t;

   typedef enum logic [2:0] {ADD, LT, XOR, OR, AND} alu_rd_sel_t;

   typedef enum logic [1:0] {CTRL, ALU, IMM, MEM} rd_source_t;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rtype_t;

   // Same word for stores and branches, split offset fields.
   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } stype_t;

   typedef union packed {
      rtype_t rtype;
      stype_t stype;
   } instr_u;

   typedef struct packed {
      logic        en;
      logic        init;     // Compare phase.
      logic        sub;
      logic        cmp_sel;  // 0 equality, 1 less-than.
      logic        cmp_neg;
      logic        cmp_uns;
      alu_rd_sel_t rd_sel;
      logic        op_b_imm;
   } alu_ctrl_t;

   typedef struct packed {
      logic       rd_en;
      logic [4:0] rd_addr;
      logic [4:0] rs1_addr;
      logic [4:0] rs2_addr;
   } rf_ctrl_t;

   typedef struct packed {
      logic en;
      logic jump;
      logic jalr;
      logic auipc;
   } ctrl_ctrl_t;

   typedef struct packed {
      logic en;    // Pulse that starts a bus request.
      logic init;
      logic we;
   } mem_ctrl_t;

endpackage

//--- design/serv_regfile.sv
`timescale 1ns/100ps
`include "serv_defines.svh"

module serv_regfile (
   input  logic                   clk,
   input  logic [`SERV_CNT_W-1:0] i_cnt,
   input  serv_pkg::rf_ctrl_t     i_rf,
   input  logic                   i_rd,
   output logic                   o_rs1,
   output logic                   o_rs2
);

   logic [`SERV_XLEN-1:0] regs [`SERV_REGS];
   logic                  rs1_bit;
   logic                  rs2_bit;

   // One bit of rd per cycle, at the same position as the reads.
   always_ff @(posedge clk) begin
      if (i_rf.rd_en && (i_rf.rd_addr != 5'd0))
         regs[i_rf.rd_addr][i_cnt] <= i_rd;
   end

   assign rs1_bit = regs[i_rf.rs1_addr][i_cnt];
   assign rs2_bit = regs[i_rf.rs2_addr][i_cnt];

   // x0 is never written; it reads as zero.
   assign o_rs1 = (i_rf.rs1_addr != 5'd0) & rs1_bit;
   assign o_rs2 = (i_rf.rs2_addr != 5'd0) & rs2_bit;

endmodule

//--- design/serv_top.sv
`timescale 1ns/100ps
`include "serv_defines.svh"

module serv_top (
   input  logic                  clk,
   input  logic                  i_rst,
   output logic [`SERV_XLEN-1:0] o_ibus_adr,
   output logic                  o_ibus_cyc,
   input  logic [`SERV_XLEN-1:0] i_ibus_rdt,
   input  logic                  i_ibus_ack,
   output logic [`SERV_XLEN-1:0] o_dbus_adr,
   output logic [`SERV_XLEN-1:0] o_dbus_dat,
   output logic                  o_dbus_we,
   output logic                  o_dbus_cyc,
   input  logic [`SERV_XLEN-1:0] i_dbus_rdt,
   input  logic                  i_dbus_ack
);

   logic [`SERV_CNT_W-1:0] cnt;
   logic                   cnt_done;
   logic                   cnt_en;
   serv_pkg::alu_ctrl_t    alu_ctrl;
   serv_pkg::rf_ctrl_t     rf_ctrl;
   serv_pkg::ctrl_ctrl_t   ctrl_ctrl;
   serv_pkg::mem_ctrl_t    mem_ctrl;
   serv_pkg::rd_source_t   rd_source;
   logic                   imm;
   logic                   rs1;
   logic                   rs2;
   logic                   alu_rd;
   logic                   alu_cmp;
   logic                   ctrl_rd;
   logic                   mem_rd;
   logic                   rd;

   serv_decode u_decode (
      .clk, .i_rst, .i_ibus_rdt, .i_ibus_ack, .i_cnt(cnt), .i_cnt_done(cnt_done),
      .i_alu_cmp(alu_cmp), .i_dbus_ack, .o_ibus_cyc, .o_cnt_en(cnt_en), .o_alu(alu_ctrl),
      .o_rf(rf_ctrl), .o_ctrl(ctrl_ctrl), .o_mem(mem_ctrl), .o_imm(imm),
      .o_rd_source(rd_source));

   serv_counter u_counter (.clk, .i_rst, .i_en(cnt_en), .o_cnt(cnt), .o_done(cnt_done));

   serv_regfile u_regfile (
      .clk, .i_cnt(cnt), .i_rf(rf_ctrl), .i_rd(rd), .o_rs1(rs1), .o_rs2(rs2));

   serv_alu u_alu (
      .clk, .i_alu(alu_ctrl), .i_rs1(rs1), .i_rs2(rs2), .i_imm(imm),
      .o_rd(alu_rd), .o_cmp(alu_cmp));

   serv_ctrl u_ctrl (
      .clk, .i_rst, .i_ctrl(ctrl_ctrl), .i_cnt_done(cnt_done), .i_imm(imm),
      .i_rs1(rs1), .o_pc(o_ibus_adr), .o_rd(ctrl_rd));

   // Address bits come from the ALU sum.
   serv_mem_if u_mem_if (
      .clk, .i_rst, .i_mem(mem_ctrl), .i_addr_bit(alu_rd), .i_rs2(rs2), .i_dbus_rdt,
      .i_dbus_ack, .o_dbus_adr, .o_dbus_dat, .o_dbus_we, .o_dbus_cyc, .o_rd(mem_rd));

   always_comb begin
      case (rd_source)
         serv_pkg::CTRL: rd = ctrl_rd;
         serv_pkg::IMM:  rd = imm;
         serv_pkg::MEM:  rd = mem_rd;
         default:        rd = alu_rd;
      endcase
   end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_serv -o tb_serv
./obj_dir/tb_serv > sim.log
cat sim.log

if grep -q "Simulation passed" sim.log; then
   exit 0
fi
exit 1

//--- test/tb_serv_model.svh
logic [31:0] rng_state;
logic [31:0] program_mem [64];
logic [31:0] ref_regs [32];
logic [31:0] ref_mem [64];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

function automatic logic [31:0] next_rand();
   rng_state = xorshift32(rng_state);
   return rng_state;
endfunction

// Initial data word, spread over the whole index.
function automatic logic [31:0] fill_word(input logic [5:0] idx);
   return ({26'd0, idx} * 32'h9e37_79b9) ^ 32'h00c0_ffee;
endfunction

function automatic logic [2:0] pick_alu_f3(input logic [2:0] k);
   case (k)
      3'd0, 3'd6: return 3'b000;
      3'd1:       return 3'b010;
      3'd2:       return 3'b011;
      3'd3, 3'd7: return 3'b100;
      3'd4:       return 3'b110;
      default:    return 3'b111;
   endcase
endfunction

// Words 0 to 6 load x1..x7, the rest is a random mix.
task automatic build_program();
   logic [31:0] r;
   logic [31:0] c;
   logic [31:0] bo;
   logic [4:0]  rd;
   logic [4:0]  rs1;
   logic [4:0]  rs2;
   logic [2:0]  f3;
   logic [2:0]  bf3;
   logic [11:0] moff;
   for (int i = 0; i < 64; i++) begin
      r    = next_rand();
      c    = next_rand();
      rd   = {2'b00, r[2:0]};
      rs1  = {2'b00, r[5:3]};
      rs2  = {2'b00, r[8:6]};
      f3   = pick_alu_f3(r[11:9]);
      bf3  = (r[11:10] == 2'b01) ? {1'b1, r[10:9]} : r[11:9];
      moff = {4'd0, r[25:20], 2'b00};
      bo   = {28'd0, r[19:16]} - 32'd8;
      if (bo == 32'd0)
         bo = 32'd1;
      bo = bo << 2;
      if (i < 7) begin
         program_mem[i] = {r[31:20], 5'd0, 3'b000, 5'(i + 1), 7'b0010011};
      end else begin
         case (c[3:0])
            4'd0, 4'd1, 4'd2, 4'd3:
               program_mem[i] = {((f3 == 3'b000) && r[20]) ? 7'h20 : 7'h00,
                                 rs2, rs1, f3, rd, 7'b0110011};
            4'd4, 4'd5, 4'd6: program_mem[i] = {r[31:20], rs1, f3, rd, 7'b0010011};
            4'd7:  program_mem[i] = {r[31:12], rd, 7'b0110111};
            4'd8:  program_mem[i] = {r[31:12], rd, 7'b0010111};
            4'd9, 4'd10:
               program_mem[i] = {moff[11:5], rs2, 5'd0, 3'b010, moff[4:0], 7'b0100011};
            4'd11, 4'd12: program_mem[i] = {moff, 5'd0, 3'b010, rd, 7'b0000011};
            4'd13:
               program_mem[i] = {bo[12], bo[10:5], rs2, rs1, bf3, bo[4:1], bo[11], 7'b1100011};
            4'd14: program_mem[i] = {bo[20], bo[10:1], bo[11], bo[19:12], rd, 7'b1101111};
            default: program_mem[i] = {moff, 5'd0, 3'b000, rd, 7'b1100111};
         endcase
      end
   end
endtask

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b, input logic sub);
   case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
   endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
   case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
   endcase
endfunction

// One instruction on the architectural state. Kind is 1 for a load, 2 for a store.
function automatic logic [31:0] ref_step(input logic [31:0] pc, input logic [31:0] ins,
                                         output logic [1:0] kind, output logic [31:0] adr,
                                         output logic [31:0] dat);
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] imm_i;
   logic [31:0] imm_s;
   logic [31:0] imm_b;
   logic [31:0] imm_j;
   logic [31:0] res;
   logic [31:0] next_pc;
   logic        wr;
   a       = ref_regs[ins[19:15]];
   b       = ref_regs[ins[24:20]];
   imm_i   = {{20{ins[31]}}, ins[31:20]};
   imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
   imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
   imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
   next_pc = pc + 32'd4;
   wr      = 1'b1;
   kind    = 2'd0;
   adr     = 32'd0;
   dat     = 32'd0;
   res     = 32'd0;
   case (ins[6:0])
      7'b0110011: res = alu_ref(ins[14:12], a, b, ins[30] & (ins[14:12] == 3'b000));
      7'b0010011: res = alu_ref(ins[14:12], a, imm_i, 1'b0);
      7'b0110111: res = {ins[31:12], 12'd0};
      7'b0010111: res = pc + {ins[31:12], 12'd0};
      7'b1101111: begin
         res     = pc + 32'd4;
         next_pc = pc + imm_j;
      end
      7'b1100111: begin
         res     = pc + 32'd4;
         next_pc = (a + imm_i) & ~32'd1;
      end
      7'b1100011: begin
         wr = 1'b0;
         if (branch_taken(ins[14:12], a, b))
            next_pc = pc + imm_b;
      end
      7'b0000011: begin
         kind = 2'd1;
         adr  = a + imm_i;
         res  = ref_mem[adr[7:2]];
      end
      7'b0100011: begin
         wr   = 1'b0;
         kind = 2'd2;
         adr  = a + imm_s;
         dat  = b;
         ref_mem[adr[7:2]] = b;
      end
      default: wr = 1'b0;
   endcase
   if (wr && (ins[11:7] != 5'd0))
      ref_regs[ins[11:7]] = res;
   return next_pc;
endfunction

//--- test/tb_serv.sv
`timescale 1ns/100ps
`include "serv_defines.svh"

module tb_serv;

   localparam int N_INSTR    = 400;
   localparam int CLK_PERIOD = 20;
   localparam int TIMEOUT_NS = (N_INSTR * 80 + 10) * CLK_PERIOD;

   logic        clk;
   logic        i_rst;
   logic [31:0] ibus_adr;
   logic        ibus_cyc;
   logic [31:0] ibus_rdt;
   logic        ibus_ack;
   logic [31:0] dbus_adr;
   logic [31:0] dbus_dat;
   logic        dbus_we;
   logic        dbus_cyc;
   logic [31:0] dbus_rdt;
   logic        dbus_ack;

   int          errors;
   int          checks;
   int          executed;
   int          ibus_wait;
   int          dbus_wait;
   logic        ibus_busy;
   logic        dbus_busy;
   logic [31:0] exp_pc;
   logic [1:0]  exp_kind;
   logic [31:0] exp_adr;
   logic [31:0] exp_dat;
   logic [31:0] data_mem [64];

   `include "tb_serv_model.svh"

   serv_top DUT (
      .clk, .i_rst, .o_ibus_adr(ibus_adr), .o_ibus_cyc(ibus_cyc), .i_ibus_rdt(ibus_rdt),
      .i_ibus_ack(ibus_ack), .o_dbus_adr(dbus_adr), .o_dbus_dat(dbus_dat),
      .o_dbus_we(dbus_we), .o_dbus_cyc(dbus_cyc), .i_dbus_rdt(dbus_rdt),
      .i_dbus_ack(dbus_ack));

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      errors++;
      $display("Error at %0t: %s expected %h got %h (errors %0d)",
               $time, name, expected, actual, errors);
   endtask

   // Both bus responders drive their acks just after the rising edge.
   always @(posedge clk) begin
      #2;
      if (ibus_ack) begin
         ibus_ack  = 1'b0;
         ibus_busy = 1'b0;
      end else if (!i_rst && ibus_cyc) begin
         if (!ibus_busy) begin
            ibus_busy = 1'b1;
            ibus_wait = int'(next_rand() % 32'd4);
         end
         if (ibus_wait == 0) begin
            ibus_ack = 1'b1;
            ibus_rdt = program_mem[ibus_adr[7:2]];
         end else begin
            ibus_wait--;
         end
      end
      if (dbus_ack) begin
         dbus_ack  = 1'b0;
         dbus_busy = 1'b0;
      end else if (!i_rst && dbus_cyc) begin
         if (!dbus_busy) begin
            dbus_busy = 1'b1;
            dbus_wait = int'(next_rand() % 32'd6);
         end
         if (dbus_wait == 0) begin
            dbus_ack = 1'b1;
            if (dbus_we)
               data_mem[dbus_adr[7:2]] = dbus_dat;
            else
               dbus_rdt = data_mem[dbus_adr[7:2]];
         end else begin
            dbus_wait--;
         end
      end
   end

   // Compare at the falling edge while bus signals are settled.
   always @(negedge clk) begin
      if (!i_rst && ibus_cyc && ibus_ack) begin
         checks++;
         if (ibus_adr !== exp_pc)
            report_mismatch("o_ibus_adr", exp_pc, ibus_adr);
         if (executed == 0 && dbus_cyc !== 1'b0) begin
            errors++;
            $display("Data bus request was active during the first fetch at %0t", $time);
         end
         if (exp_kind != 2'd0) begin
            errors++;
            $display("Data access of the previous instruction never happened (%0t)", $time);
         end
         exp_pc = ref_step(exp_pc, program_mem[exp_pc[7:2]], exp_kind, exp_adr, exp_dat);
         executed++;
      end
      if (!i_rst && dbus_cyc && dbus_ack) begin
         checks++;
         if (exp_kind == 2'd0) begin
            errors++;
            $display("Data bus access at %0t that no instruction asked for", $time);
         end else begin
            if (dbus_we !== (exp_kind == 2'd2))
               report_mismatch("o_dbus_we", {31'd0, exp_kind == 2'd2}, {31'd0, dbus_we});
            if (dbus_adr !== exp_adr)
               report_mismatch("o_dbus_adr", exp_adr, dbus_adr);
            if (exp_kind == 2'd2 && dbus_dat !== exp_dat)
               report_mismatch("o_dbus_dat", exp_dat, dbus_dat);
            exp_kind = 2'd0;
         end
      end
   end

   initial begin
      clk       = 1'b0;
      i_rst     = 1'b1;
      ibus_rdt  = 32'd0;
      ibus_ack  = 1'b0;
      dbus_rdt  = 32'd0;
      dbus_ack  = 1'b0;
      errors    = 0;
      checks    = 0;
      executed  = 0;
      ibus_wait = 0;
      dbus_wait = 0;
      ibus_busy = 1'b0;
      dbus_busy = 1'b0;
      exp_pc    = `SERV_RESET_PC;
      exp_kind  = 2'd0;
      exp_adr   = 32'd0;
      exp_dat   = 32'd0;
      rng_state = 32'h7666_0a42;
      build_program();
      for (int i = 0; i < 64; i++) begin
         data_mem[i] = fill_word(6'(i));
         ref_mem[i]  = fill_word(6'(i));
      end
      for (int i = 0; i < 32; i++)
         ref_regs[i] = 32'd0;
      repeat (10) @(posedge clk);
      #2;
      i_rst <= 1'b0;
      // The next fetch shows the PC and data access of the last instruction.
      wait (executed > N_INSTR);
      $display("Checks: %0d, instructions: %0d, errors: %0d", checks, executed - 1, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   // The slowest instruction with the longest data wait stays under 80 cycles.
   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the core did not complete %0d instructions in time", N_INSTR);
      $display("Simulation failed");
      $finish;
   end

endmodule
